// File: all.f
+incdir+verification
rtl/axi_pkg.sv
rtl/soc_pkg.sv
rtl/axi_if.sv
rtl/bus_arbiter.sv
rtl/clint_timer.sv
rtl/sram_slave.sv
rtl/soc_bus.sv
verification/soc_bus_tb.sv

// File: verification/soc_bus_tb_tasks.svh
`ifndef SOC_BUS_TB_TASKS_SVH
`define SOC_BUS_TB_TASKS_SVH

// xorshift32
function automatic logic [31:0] next_rand();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
endfunction

function automatic bit rand_bit();
    logic [31:0] r;
    r = next_rand();
    return r[7];
endfunction

task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
        $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        $display("tests failed");
        $fatal(1, "value mismatch");
    end
endtask

task automatic fail_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped");
endtask

// one AR request followed by every R beat collected into rd_data and rd_resp
task automatic read_burst(input bit use_lsu, input logic [31:0] addr, input logic [3:0] id,
                          input logic [7:0] len, input bit stall);
    int waited;
    bit ar_hit;
    bit r_hit;
    bit done;
    rd_data.delete();
    rd_resp.delete();
    rd_lsu   = use_lsu;
    ar_addr  = addr;
    ar_id    = id;
    ar_len   = len;
    ar_valid = 1'b1;
    r_ready  = stall ? rand_bit() : 1'b1;
    waited   = 0;
    done     = 1'b0;
    while (!done) begin
        @(negedge clk);  // outputs settled before the transfer edge
        ar_hit = ar_valid && ar_ready;
        r_hit  = r_valid && r_ready;
        if (r_hit) begin
            if (rd_data.size() == 0) first_r_time = $time;
            rd_data.push_back(r_data);
            rd_resp.push_back(r_resp);
            check(r_id, id, "rid");
            check(r_last, rd_data.size() == len + 1, "rlast on final beat only");
            done = r_last;
        end
        @(posedge clk);
        #1;
        if (ar_hit) ar_valid = 1'b0;
        r_ready = !done && (stall ? rand_bit() : 1'b1);
        waited++;
        if (!done && waited > TIMEOUT_CYCLES) begin
            if (ar_valid) fail_timeout("the AR handshake");
            else fail_timeout("the R beats");
        end
    end
endtask

// single-beat lsu write that leaves its result in wr_resp and wr_id
task automatic write_single(input logic [31:0] addr, input logic [3:0] id,
                            input logic [31:0] data, input logic [3:0] strb, input bit stall);
    int waited;
    bit aw_hit;
    bit w_hit;
    bit done;
    lsu_awaddr  = addr;
    lsu_awid    = id;
    lsu_wdata   = data;
    lsu_wstrb   = strb;
    lsu_awvalid = 1'b1;
    lsu_wvalid  = 1'b1;
    lsu_bready  = stall ? rand_bit() : 1'b1;
    waited      = 0;
    done        = 1'b0;
    while (!done) begin
        @(negedge clk);
        aw_hit = lsu_awvalid && lsu_awready;
        w_hit  = lsu_wvalid && lsu_wready;
        if (lsu_bvalid && lsu_bready) begin
            wr_resp     = lsu_bresp;
            wr_id       = lsu_bid;
            last_b_time = $time;
            done        = 1'b1;
        end
        @(posedge clk);
        #1;
        if (aw_hit) lsu_awvalid = 1'b0;
        if (w_hit) lsu_wvalid = 1'b0;
        lsu_bready = !done && (stall ? rand_bit() : 1'b1);
        waited++;
        if (!done && waited > TIMEOUT_CYCLES) begin
            if (lsu_awvalid) fail_timeout("the AW handshake");
            else if (lsu_wvalid) fail_timeout("the W handshake");
            else fail_timeout("the B response");
        end
    end
endtask

task automatic wait_mtip(input logic level);
    int waited;
    waited = 0;
    while (mtip !== level) begin
        @(posedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
            if (level) fail_timeout("mtip to rise");
            else fail_timeout("mtip to fall");
        end
    end
endtask

`endif

// File: verification/soc_bus_tb.sv
`timescale 1ns/1ns

module soc_bus_tb import axi_pkg::*, soc_pkg::*; ();

    localparam logic [31:0] SEED           = 32'h808059dd;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          REGION         = 64;  // words preloaded from SRAM_BASE

    logic        clk = 1'b0;
    logic        rst;
    logic        ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready, ifu_rlast;
    logic [31:0] ifu_araddr, ifu_rdata;
    logic [3:0]  ifu_arid, ifu_rid;
    logic [7:0]  ifu_arlen;
    logic [1:0]  ifu_rresp;
    logic        lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready, lsu_rlast;
    logic [31:0] lsu_araddr, lsu_rdata;
    logic [3:0]  lsu_arid, lsu_rid;
    logic [7:0]  lsu_arlen;
    logic [1:0]  lsu_rresp;
    logic        lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    logic [31:0] lsu_awaddr, lsu_wdata;
    logic [3:0]  lsu_awid, lsu_wstrb, lsu_bid;
    logic [1:0]  lsu_bresp;
    logic        mtip;

    // one read requester steered to the ifu or the lsu port
    logic        rd_lsu, ar_valid, r_ready;
    logic [31:0] ar_addr;
    logic [3:0]  ar_id;
    logic [7:0]  ar_len;
    wire         ar_ready = rd_lsu ? lsu_arready : ifu_arready;
    wire         r_valid  = rd_lsu ? lsu_rvalid : ifu_rvalid;
    wire         r_last   = rd_lsu ? lsu_rlast : ifu_rlast;
    wire  [31:0] r_data   = rd_lsu ? lsu_rdata : ifu_rdata;
    wire  [1:0]  r_resp   = rd_lsu ? lsu_rresp : ifu_rresp;
    wire  [3:0]  r_id     = rd_lsu ? lsu_rid : ifu_rid;

    assign ifu_arvalid = ar_valid & ~rd_lsu;
    assign lsu_arvalid = ar_valid & rd_lsu;
    assign ifu_rready  = r_ready & ~rd_lsu;
    assign lsu_rready  = r_ready & rd_lsu;
    assign ifu_araddr  = ar_addr;
    assign lsu_araddr  = ar_addr;
    assign ifu_arid    = ar_id;
    assign lsu_arid    = ar_id;
    assign ifu_arlen   = ar_len;
    assign lsu_arlen   = ar_len;

    logic [31:0] rnd_state = SEED;
    logic [31:0] ref_mem [SRAM_WORDS];
    logic [31:0] rd_data [$];
    logic [1:0]  rd_resp [$];
    logic [1:0]  wr_resp;
    logic [3:0]  wr_id;
    time         last_b_time, first_r_time;

    // expected word after a strobed write
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    always #10 clk = ~clk;

    soc_bus soc_bus_i (.*);

    `include "soc_bus_tb_tasks.svh"

    // ####################################################################
    // test sequence
    // ####################################################################

    initial begin
        logic [31:0] rnd, addr, data, t0;
        logic [3:0]  id, strb;
        logic [7:0]  len;
        int          word;
        rst         = 1'b1;
        rd_lsu      = 1'b0;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        ar_addr     = '0;
        ar_id       = '0;
        ar_len      = '0;
        lsu_awvalid = 1'b0;
        lsu_awaddr  = '0;
        lsu_awid    = '0;
        lsu_wvalid  = 1'b0;
        lsu_wdata   = '0;
        lsu_wstrb   = '0;
        lsu_bready  = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        check({ifu_arready, ifu_rvalid, lsu_arready, lsu_rvalid, lsu_awready, lsu_wready,
               lsu_bvalid, mtip}, '0, "valid, ready and mtip after reset");

        for (int i = 0; i < REGION; i++) begin
            addr = SRAM_BASE + 4 * i;
            write_single(addr, 4'(i), addr ^ 32'h3c5a_96e1, 4'hf, 1'b0);
            ref_mem[i] = addr ^ 32'h3c5a_96e1;
            check(wr_resp, resp_okay, "preload bresp");
        end

        // lsu strobed writes with a read back of each
        for (int n = 0; n < 20; n++) begin
            rnd  = next_rand();
            word = rnd % REGION;
            data = next_rand();
            strb = rnd[11:8];
            id   = rnd[15:12];
            write_single(SRAM_BASE + 4 * word, id, data, strb, 1'b1);
            ref_mem[word] = merge_bytes(ref_mem[word], data, strb);
            check(wr_resp, resp_okay, "lsu bresp");
            check(wr_id, id, "lsu bid");
            read_burst(1'b1, SRAM_BASE + 4 * word, ~id, 8'd0, 1'b0);
            check(rd_data.size(), 1, "lsu beat count");
            check(rd_data[0], ref_mem[word], "lsu read back");
        end

        for (int n = 0; n < 12; n++) begin
            rnd  = next_rand();
            len  = rnd[2:0];
            word = rnd[31:8] % (REGION - 8);
            read_burst(1'b0, SRAM_BASE + 4 * word, rnd[7:4], len, 1'b1);
            check(rd_data.size(), len + 1, "ifu beat count");
            for (int i = 0; i <= len; i++) begin
                check(rd_data[i], ref_mem[word + i], "ifu burst data");
                check(rd_resp[i], resp_okay, "ifu rresp");
            end
        end

        // both masters ask in the same cycle
        data = next_rand();
        fork
            write_single(SRAM_BASE + 4 * 5, 4'h9, data, 4'hf, 1'b0);
            read_burst(1'b0, SRAM_BASE + 4 * 20, 4'h3, 8'd3, 1'b1);
        join
        ref_mem[5] = data;
        check(wr_resp, resp_okay, "priority bresp");
        check(wr_id, 4'h9, "priority bid");
        check(last_b_time < first_r_time, 1'b1, "lsu finishes before first ifu beat");
        check(rd_data.size(), 4, "priority ifu beat count");
        for (int i = 0; i < 4; i++) begin
            check(rd_data[i], ref_mem[20 + i], "priority ifu data");
        end

        addr = SRAM_BASE + SRAM_WORDS * 4;  // same array index as word 0
        read_burst(1'b1, addr, 4'h1, 8'd1, 1'b0);
        check(rd_data.size(), 2, "out of range beat count");
        for (int i = 0; i < 2; i++) begin
            check(rd_data[i], 32'h0, "out of range rdata");
            check(rd_resp[i], resp_slverr, "out of range rresp");
        end
        write_single(addr, 4'h2, ~ref_mem[0], 4'hf, 1'b0);
        check(wr_resp, resp_slverr, "out of range bresp");
        read_burst(1'b1, SRAM_BASE, 4'h3, 8'd0, 1'b0);
        check(rd_data[0], ref_mem[0], "word 0 after dropped write");

        read_burst(1'b1, CLINT_BASE + MTIME_LO, 4'h4, 8'd0, 1'b0);
        t0 = rd_data[0];
        read_burst(1'b1, CLINT_BASE + MTIME_LO, 4'h5, 8'd0, 1'b0);
        check(rd_data[0] >= t0, 1'b1, "mtime_lo does not decrease");
        write_single(CLINT_BASE + MTIMECMP_LO, 4'h6, 32'h0, 4'hf, 1'b0);
        write_single(CLINT_BASE + MTIMECMP_HI, 4'h7, 32'h0, 4'hf, 1'b0);
        check(wr_resp, resp_okay, "mtimecmp bresp");
        wait_mtip(1'b1);
        write_single(CLINT_BASE + MTIMECMP_LO, 4'h6, 32'hffff_ffff, 4'hf, 1'b0);
        write_single(CLINT_BASE + MTIMECMP_HI, 4'h7, 32'hffff_ffff, 4'hf, 1'b0);
        wait_mtip(1'b0);

        $display("all tests passed");
        $finish;
    end

endmodule

// File: rtl/soc_bus.sv
`timescale 1ns/1ns

module soc_bus import axi_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // ifu read
    input  logic              ifu_arvalid,
    output logic              ifu_arready,
    input  logic [ADDR_W-1:0] ifu_araddr,
    input  logic [ID_W-1:0]   ifu_arid,
    input  logic [LEN_W-1:0]  ifu_arlen,
    output logic              ifu_rvalid,
    input  logic              ifu_rready,
    output logic [DATA_W-1:0] ifu_rdata,
    output logic [1:0]        ifu_rresp,
    output logic              ifu_rlast,
    output logic [ID_W-1:0]   ifu_rid,
    // lsu read
    input  logic              lsu_arvalid,
    output logic              lsu_arready,
    input  logic [ADDR_W-1:0] lsu_araddr,
    input  logic [ID_W-1:0]   lsu_arid,
    input  logic [LEN_W-1:0]  lsu_arlen,
    output logic              lsu_rvalid,
    input  logic              lsu_rready,
    output logic [DATA_W-1:0] lsu_rdata,
    output logic [1:0]        lsu_rresp,
    output logic              lsu_rlast,
    output logic [ID_W-1:0]   lsu_rid,
    // lsu write
    input  logic              lsu_awvalid,
    output logic              lsu_awready,
    input  logic [ADDR_W-1:0] lsu_awaddr,
    input  logic [ID_W-1:0]   lsu_awid,
    input  logic              lsu_wvalid,
    output logic              lsu_wready,
    input  logic [DATA_W-1:0] lsu_wdata,
    input  logic [STRB_W-1:0] lsu_wstrb,
    output logic              lsu_bvalid,
    input  logic              lsu_bready,
    output logic [1:0]        lsu_bresp,
    output logic [ID_W-1:0]   lsu_bid,
    output logic              mtip
);

    axi_if ifu_bus ();
    axi_if lsu_bus ();
    axi_if sram_bus ();
    axi_if clint_bus ();

    assign ifu_bus.arvalid = ifu_arvalid;
    assign ifu_bus.araddr  = ifu_araddr;
    assign ifu_bus.arid    = ifu_arid;
    assign ifu_bus.arlen   = ifu_arlen;
    assign ifu_bus.rready  = ifu_rready;
    assign ifu_arready     = ifu_bus.arready;
    assign ifu_rvalid      = ifu_bus.rvalid;
    assign ifu_rdata       = ifu_bus.rdata;
    assign ifu_rresp       = ifu_bus.rresp;
    assign ifu_rlast       = ifu_bus.rlast;
    assign ifu_rid         = ifu_bus.rid;

    assign lsu_bus.arvalid = lsu_arvalid;
    assign lsu_bus.araddr  = lsu_araddr;
    assign lsu_bus.arid    = lsu_arid;
    assign lsu_bus.arlen   = lsu_arlen;
    assign lsu_bus.rready  = lsu_rready;
    assign lsu_arready     = lsu_bus.arready;
    assign lsu_rvalid      = lsu_bus.rvalid;
    assign lsu_rdata       = lsu_bus.rdata;
    assign lsu_rresp       = lsu_bus.rresp;
    assign lsu_rlast       = lsu_bus.rlast;
    assign lsu_rid         = lsu_bus.rid;

    assign lsu_bus.awvalid = lsu_awvalid;
    assign lsu_bus.awaddr  = lsu_awaddr;
    assign lsu_bus.awid    = lsu_awid;
    assign lsu_bus.wvalid  = lsu_wvalid;
    assign lsu_bus.wdata   = lsu_wdata;
    assign lsu_bus.wstrb   = lsu_wstrb;
    assign lsu_bus.bready  = lsu_bready;
    assign lsu_awready     = lsu_bus.awready;
    assign lsu_wready      = lsu_bus.wready;
    assign lsu_bvalid      = lsu_bus.bvalid;
    assign lsu_bresp       = lsu_bus.bresp;
    assign lsu_bid         = lsu_bus.bid;

    bus_arbiter bus_arbiter_i (
        .clk   (clk),
        .rst   (rst),
        .ifu   (ifu_bus.read_slave),
        .lsu   (lsu_bus.slave),
        .sram  (sram_bus.master),
        .clint (clint_bus.master)
    );

    sram_slave sram_slave_i (
        .clk (clk),
        .rst (rst),
        .bus (sram_bus.slave)
    );

    clint_timer clint_timer_i (
        .clk  (clk),
        .rst  (rst),
        .bus  (clint_bus.slave),
        .mtip (mtip)
    );

endmodule

// File: rtl/sram_slave.sv
`timescale 1ns/1ns

module sram_slave import axi_pkg::*, soc_pkg::*; (
    input  logic clk,
    input  logic rst,
    axi_if.slave bus
);

    logic [DATA_W-1:0]             mem [SRAM_WORDS];
    xfer_e                         mode;
    logic [ADDR_W-1:0]             addr;        // byte address of current beat
    logic [LEN_W-1:0]              beats_left;
    logic [ID_W-1:0]               id;
    resp_e                         wr_resp;
    logic [$clog2(SRAM_WORDS)-1:0] wrd;
    logic                          in_range;
    logic                          ar_fire, aw_fire, r_fire, w_fire;

    assign ar_fire  = bus.arvalid && bus.arready;
    assign aw_fire  = bus.awvalid && bus.awready;
    assign r_fire   = bus.rvalid && bus.rready;
    assign w_fire   = bus.wvalid && bus.wready;
    assign in_range = (addr >= SRAM_BASE) && (addr < SRAM_BASE + SRAM_WORDS * 4);
    assign wrd      = addr[$clog2(SRAM_WORDS)+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= xfer_idle;
        end else begin
            case (mode)
                xfer_idle: begin
                    if (ar_fire) begin
                        mode <= xfer_read;
                    end else if (aw_fire) begin
                        mode <= xfer_wdata;
                    end
                end
                xfer_read:  if (r_fire && bus.rlast) mode <= xfer_idle;
                xfer_wdata: if (w_fire) mode <= xfer_wresp;
                default:    if (bus.bready) mode <= xfer_idle;
            endcase
        end
    end

    // ####################################################################
    // burst engine and array
    // ####################################################################

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            addr       <= bus.araddr;
            beats_left <= bus.arlen;
            id         <= bus.arid;
        end else if (aw_fire) begin
            addr <= bus.awaddr;
            id   <= bus.awid;
        end else if (r_fire) begin
            addr       <= addr + 32'd4;  // incrementing 4-byte beats
            beats_left <= beats_left - 1'b1;
        end
        if (w_fire) begin
            wr_resp <= in_range ? resp_okay : resp_slverr;
            if (in_range) mem[wrd] <= strb_merge(mem[wrd], bus.wdata, bus.wstrb);
        end
    end

    assign bus.arready = (mode == xfer_idle);
    assign bus.awready = (mode == xfer_idle) && !bus.arvalid;
    assign bus.rvalid  = (mode == xfer_read);
    assign bus.rdata   = in_range ? mem[wrd] : '0;
    assign bus.rresp   = in_range ? resp_okay : resp_slverr;
    assign bus.rlast   = (beats_left == '0);
    assign bus.rid     = id;
    assign bus.wready  = (mode == xfer_wdata);
    assign bus.bvalid  = (mode == xfer_wresp);
    assign bus.bresp   = wr_resp;
    assign bus.bid     = id;

    // one transaction at a time
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        (ar_fire || aw_fire) |=> !(ar_fire || aw_fire));

endmodule

// File: rtl/clint_timer.sv
`timescale 1ns/1ns

module clint_timer import axi_pkg::*, soc_pkg::*; (
    input  logic clk,
    input  logic rst,
    axi_if.slave bus,
    output logic mtip
);

    xfer_e                          mode;
    logic [$clog2(MTIME_DIV)-1:0]   div_cnt;
    logic                           tick;
    logic [63:0]                    mtime, mtimecmp;
    logic [DATA_W-1:0]              regs [4];
    logic [1:0]                     idx;       // register index that wraps in the window
    logic [3:0]                     off;
    logic [LEN_W-1:0]               beats_left;
    logic [ID_W-1:0]                id;
    logic [DATA_W-1:0]              rdata_q;
    logic                           ar_fire, aw_fire, r_fire, w_fire;

    assign ar_fire = bus.arvalid && bus.arready;
    assign aw_fire = bus.awvalid && bus.awready;
    assign r_fire  = bus.rvalid && bus.rready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign off     = {idx, 2'b00};
    assign tick    = (div_cnt == MTIME_DIV - 1);

    always_comb begin
        regs[MTIME_LO[3:2]]    = mtime[31:0];
        regs[MTIME_HI[3:2]]    = mtime[63:32];
        regs[MTIMECMP_LO[3:2]] = mtimecmp[31:0];
        regs[MTIMECMP_HI[3:2]] = mtimecmp[63:32];
    end

    // ####################################################################
    // timer and bus phase
    // ####################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode     <= xfer_idle;
            div_cnt  <= '0;
            mtime    <= '0;
            mtimecmp <= '1;
            mtip     <= 1'b0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) mtime <= mtime + 64'd1;
            if (w_fire) begin  // a bus write beats the tick
                case (off)
                    MTIME_LO:    mtime[31:0]     <= strb_merge(mtime[31:0], bus.wdata, bus.wstrb);
                    MTIME_HI:    mtime[63:32]    <= strb_merge(mtime[63:32], bus.wdata, bus.wstrb);
                    MTIMECMP_LO: mtimecmp[31:0]  <= strb_merge(mtimecmp[31:0], bus.wdata,
                                                               bus.wstrb);
                    default:     mtimecmp[63:32] <= strb_merge(mtimecmp[63:32], bus.wdata,
                                                               bus.wstrb);
                endcase
            end
            mtip <= (mtime >= mtimecmp);
            case (mode)
                xfer_idle: begin
                    if (ar_fire) begin
                        mode <= xfer_read;
                    end else if (aw_fire) begin
                        mode <= xfer_wdata;
                    end
                end
                xfer_read:  if (r_fire && bus.rlast) mode <= xfer_idle;
                xfer_wdata: if (w_fire) mode <= xfer_wresp;
                default:    if (bus.bready) mode <= xfer_idle;
            endcase
        end
    end

    // read data is captured per beat so a stalled beat does not move with mtime
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            idx        <= bus.araddr[3:2];
            beats_left <= bus.arlen;
            id         <= bus.arid;
            rdata_q    <= regs[bus.araddr[3:2]];
        end else if (aw_fire) begin
            idx <= bus.awaddr[3:2];
            id  <= bus.awid;
        end else if (r_fire) begin
            idx        <= idx + 2'd1;
            beats_left <= beats_left - 1'b1;
            rdata_q    <= regs[idx + 2'd1];
        end
    end

    assign bus.arready = (mode == xfer_idle);
    assign bus.awready = (mode == xfer_idle) && !bus.arvalid;
    assign bus.rvalid  = (mode == xfer_read);
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = resp_okay;
    assign bus.rlast   = (beats_left == '0);
    assign bus.rid     = id;
    assign bus.wready  = (mode == xfer_wdata);
    assign bus.bvalid  = (mode == xfer_wresp);
    assign bus.bresp   = resp_okay;
    assign bus.bid     = id;

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import axi_pkg::*, soc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    axi_if.read_slave ifu,
    axi_if.slave      lsu,
    axi_if.master     sram,
    axi_if.master     clint
);

    arb_state_e        state;
    target_e           target;
    logic              g_ifu, g_lsu, to_clint;
    logic [ADDR_W-1:0] req_addr;
    logic              r_done, b_done;

    // request side of the granted master
    logic              m_arvalid, m_rready;
    logic [ADDR_W-1:0] m_araddr;
    logic [ID_W-1:0]   m_arid;
    logic [LEN_W-1:0]  m_arlen;

    // response side of the chosen slave
    logic              s_arready, s_rvalid, s_rlast, s_awready, s_wready, s_bvalid;
    logic [DATA_W-1:0] s_rdata;
    resp_e             s_rresp, s_bresp;
    logic [ID_W-1:0]   s_rid, s_bid;

    function automatic target_e pick_target(input logic [ADDR_W-1:0] a);
        return (a >= CLINT_BASE && a < CLINT_BASE + CLINT_SPAN) ? tgt_clint : tgt_sram;
    endfunction

    // ####################################################################
    // grant fsm with lsu priority
    // ####################################################################

    assign req_addr = lsu.arvalid ? lsu.araddr : (lsu.awvalid ? lsu.awaddr : ifu.araddr);
    assign r_done   = s_rvalid && m_rready && s_rlast;
    assign b_done   = s_bvalid && lsu.bready && g_lsu;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            target <= tgt_sram;
        end else begin
            case (state)
                st_idle: begin
                    if (lsu.arvalid || lsu.awvalid) begin
                        state <= st_lsu;
                    end else if (ifu.arvalid) begin
                        state <= st_ifu;
                    end
                    target <= pick_target(req_addr);  // only kept once granted
                end
                default: begin
                    if (r_done || b_done) state <= st_idle;
                end
            endcase
        end
    end

    assign g_ifu    = (state == st_ifu);
    assign g_lsu    = (state == st_lsu);
    assign to_clint = (target == tgt_clint);

    // ####################################################################
    // channel mux
    // ####################################################################

    assign m_arvalid = g_lsu ? lsu.arvalid : (g_ifu & ifu.arvalid);
    assign m_araddr  = g_lsu ? lsu.araddr  : ifu.araddr;
    assign m_arid    = g_lsu ? lsu.arid    : ifu.arid;
    assign m_arlen   = g_lsu ? lsu.arlen   : ifu.arlen;
    assign m_rready  = g_lsu ? lsu.rready  : (g_ifu & ifu.rready);

    assign sram.arvalid  = m_arvalid & ~to_clint;
    assign sram.araddr   = m_araddr;
    assign sram.arid     = m_arid;
    assign sram.arlen    = m_arlen;
    assign sram.rready   = m_rready & ~to_clint;
    assign sram.awvalid  = g_lsu & lsu.awvalid & ~to_clint;
    assign sram.awaddr   = lsu.awaddr;
    assign sram.awid     = lsu.awid;
    assign sram.wvalid   = g_lsu & lsu.wvalid & ~to_clint;
    assign sram.wdata    = lsu.wdata;
    assign sram.wstrb    = lsu.wstrb;
    assign sram.bready   = g_lsu & lsu.bready & ~to_clint;

    assign clint.arvalid = m_arvalid & to_clint;
    assign clint.araddr  = m_araddr;
    assign clint.arid    = m_arid;
    assign clint.arlen   = m_arlen;
    assign clint.rready  = m_rready & to_clint;
    assign clint.awvalid = g_lsu & lsu.awvalid & to_clint;
    assign clint.awaddr  = lsu.awaddr;
    assign clint.awid    = lsu.awid;
    assign clint.wvalid  = g_lsu & lsu.wvalid & to_clint;
    assign clint.wdata   = lsu.wdata;
    assign clint.wstrb   = lsu.wstrb;
    assign clint.bready  = g_lsu & lsu.bready & to_clint;

    assign s_arready = to_clint ? clint.arready : sram.arready;
    assign s_rvalid  = to_clint ? clint.rvalid  : sram.rvalid;
    assign s_rdata   = to_clint ? clint.rdata   : sram.rdata;
    assign s_rresp   = to_clint ? clint.rresp   : sram.rresp;
    assign s_rlast   = to_clint ? clint.rlast   : sram.rlast;
    assign s_rid     = to_clint ? clint.rid     : sram.rid;
    assign s_awready = to_clint ? clint.awready : sram.awready;
    assign s_wready  = to_clint ? clint.wready  : sram.wready;
    assign s_bvalid  = to_clint ? clint.bvalid  : sram.bvalid;
    assign s_bresp   = to_clint ? clint.bresp   : sram.bresp;
    assign s_bid     = to_clint ? clint.bid     : sram.bid;

    assign ifu.arready = g_ifu & s_arready;
    assign ifu.rvalid  = g_ifu & s_rvalid;
    assign ifu.rdata   = g_ifu ? s_rdata : '0;
    assign ifu.rresp   = g_ifu ? s_rresp : resp_okay;
    assign ifu.rlast   = g_ifu & s_rlast;
    assign ifu.rid     = g_ifu ? s_rid : '0;

    assign lsu.arready = g_lsu & s_arready;
    assign lsu.rvalid  = g_lsu & s_rvalid;
    assign lsu.rdata   = g_lsu ? s_rdata : '0;
    assign lsu.rresp   = g_lsu ? s_rresp : resp_okay;
    assign lsu.rlast   = g_lsu & s_rlast;
    assign lsu.rid     = g_lsu ? s_rid : '0;
    assign lsu.awready = g_lsu & s_awready;
    assign lsu.wready  = g_lsu & s_wready;
    assign lsu.bvalid  = g_lsu & s_bvalid;
    assign lsu.bresp   = g_lsu ? s_bresp : resp_okay;
    assign lsu.bid     = g_lsu ? s_bid : '0;

    // routing is fixed for the whole grant
    a_target_held: assert property (@(posedge clk) disable iff (rst)
        state != st_idle |=> $stable(target));

    a_one_slave: assert property (@(posedge clk) disable iff (rst)
        !((sram.arvalid || sram.awvalid || sram.wvalid) &&
          (clint.arvalid || clint.awvalid || clint.wvalid)));

endmodule

// File: rtl/axi_if.sv
`timescale 1ns/1ns

interface axi_if import axi_pkg::*; ();

    // read address / data
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic [ID_W-1:0]   arid;
    logic [LEN_W-1:0]  arlen;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    resp_e             rresp;
    logic              rlast;
    logic [ID_W-1:0]   rid;

    // write address / data / response, single beat
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic [ID_W-1:0]   awid;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    resp_e             bresp;
    logic [ID_W-1:0]   bid;

    modport master (
        output arvalid, araddr, arid, arlen, rready,
        output awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        input  arready, rvalid, rdata, rresp, rlast, rid,
        input  awready, wready, bvalid, bresp, bid
    );

    modport slave (
        input  arvalid, araddr, arid, arlen, rready,
        input  awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        output arready, rvalid, rdata, rresp, rlast, rid,
        output awready, wready, bvalid, bresp, bid
    );

    modport read_master (
        output arvalid, araddr, arid, arlen, rready,
        input  arready, rvalid, rdata, rresp, rlast, rid
    );

    modport read_slave (
        input  arvalid, araddr, arid, arlen, rready,
        output arready, rvalid, rdata, rresp, rlast, rid
    );

endinterface

// File: rtl/soc_pkg.sv
package soc_pkg;

    // address map
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam int          CLINT_SPAN = 16;           // bytes
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
    localparam int          SRAM_WORDS = 1024;

    // clint register offsets
    localparam logic [3:0] MTIME_LO    = 4'h0;
    localparam logic [3:0] MTIME_HI    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO = 4'h8;
    localparam logic [3:0] MTIMECMP_HI = 4'hc;

    localparam int MTIME_DIV = 4;  // clk cycles per mtime tick

    typedef enum logic [1:0] {
        st_idle,
        st_ifu,
        st_lsu
    } arb_state_e;

    typedef enum logic {
        tgt_sram,
        tgt_clint
    } target_e;

endpackage

// File: rtl/axi_pkg.sv
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int STRB_W = 4;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // phase of the transaction a slave is serving
    typedef enum logic [1:0] {
        xfer_idle,
        xfer_read,
        xfer_wdata,  // aw taken, waiting for w
        xfer_wresp   // b pending
    } xfer_e;

    // byte merge under a write strobe
    function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] data,
                                                     input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

endpackage
